// File: softmax.f
softmax_pkg.sv
softmax_max_select.sv
softmax_exp.sv
softmax_divider.sv
softmax_running_stats.sv
safe_softmax.sv
softmax_top.sv
tb_softmax_properties.sv
tb_softmax.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the softmax testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_softmax -f softmax.f
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/Vtb_softmax +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" sim.log; then
    echo "simulation reported errors"
    exit 1
fi

echo "simulation passed"
exit 0

// File: tb_softmax.sv
`timescale 1ns/100ps
module tb_softmax;

    localparam int D_W    = 8;
    localparam int NUM    = 16;
    localparam int CHUNKS = 10;
    localparam int LIMIT  = 8 + (CHUNKS + 4) * (softmax_pkg::DIV_STEPS + 10); // four extra slots

    logic                          I_CLK;
    logic                          I_RST_N;
    logic                          I_START;
    logic                          I_CLEAR;
    logic signed [D_W-1:0]         I_DATA [0:NUM-1];
    logic [7:0]                    O_DATA [0:NUM-1];
    logic                          O_VLD;
    logic signed [D_W-1:0]         O_X_MAX;
    logic [softmax_pkg::SUM_W-1:0] O_EXP_SUM;

    int    cycles = 0;
    int    model_max;
    int    model_sum;
    int    expect_q [$]; // per chunk NUM probabilities then max and sum
    string test_name;

    softmax_top #(.D_W(D_W), .NUM(NUM)) i_dut (.*);

    initial begin
        I_CLK = 1'b0;
        forever #10 I_CLK = ~I_CLK;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check(input string name, input int expected, input int actual);
        if (expected != actual) begin
            stop_run($sformatf("Fail %s: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    // e^d in Q1.15 for integer d <= 0
    function automatic int exp_ref(input int d);
        int t;
        t = ((d < -128) ? -128 : d) * softmax_pkg::LOG2E_Q8; // argument floors at -128.0
        if (-(t >>> 8) > 15) begin
            return 0;
        end
        return ((256 + (t & 255)) << 7) >> (-(t >>> 8));
    endfunction

    function automatic void softmax_ref();
        int e [0:NUM-1];
        int m;
        int s;
        int q;
        m = model_max;
        for (int i = 0; i < NUM; i++) begin
            m = (I_DATA[i] > m) ? I_DATA[i] : m;
        end
        s = int'((longint'(model_sum) * exp_ref(model_max - m)) >>> 15);
        for (int i = 0; i < NUM; i++) begin
            e[i] = exp_ref(I_DATA[i] - m);
            s += e[i] >>> 10; // Q1.15 down to Q11.5
        end
        s = (s > 65535) ? 65535 : s;
        for (int i = 0; i < NUM; i++) begin
            q = (s == 0) ? 0 : (e[i] * 64) / s;
            q = (q >>> 8) + ((q >>> 7) & 1);
            expect_q.push_back((q > 255) ? 255 : q);
        end
        expect_q.push_back(m);
        expect_q.push_back(s);
        model_max = m;
        model_sum = s;
    endfunction

    task automatic fill_random(input int lo, input int hi);
        for (int i = 0; i < NUM; i++) begin
            I_DATA[i] = D_W'(lo + int'($urandom_range(hi - lo)));
        end
    endtask

    task automatic clear_stats();
        I_CLEAR = 1'b1;
        @(negedge I_CLK);
        I_CLEAR = 1'b0;
        model_max = -(1 << (D_W - 1));
        model_sum = 0;
    endtask

    task automatic run_chunk(input string name);
        test_name = name;
        softmax_ref();
        I_START = 1'b1;
        @(negedge I_CLK);
        while (!O_VLD) begin
            @(negedge I_CLK);
        end
        I_START = 1'b0; // back to IDLE without a second run
        @(negedge I_CLK);
    endtask

    initial begin
        string name;
        forever begin
            @(negedge I_CLK);
            if (O_VLD) begin
                name = test_name;
                if (expect_q.size() == 0) begin
                    stop_run($sformatf("O_VLD pulsed in %s while no chunk was running", name));
                end else begin
                    for (int i = 0; i < NUM; i++) begin
                        check($sformatf("%s prob[%0d]", name, i), expect_q.pop_front(),
                              int'(O_DATA[i]));
                    end
                    @(negedge I_CLK); // stats load on the pulse
                    check({name, " x_max"}, expect_q.pop_front(), int'(O_X_MAX));
                    check({name, " exp_sum"}, expect_q.pop_front(), int'(O_EXP_SUM));
                end
            end
        end
    end

    always @(posedge I_CLK) begin
        cycles++;
        if (cycles > LIMIT) begin
            stop_run($sformatf("Timeout: run still going after %0d cycles", LIMIT));
        end
    end

    initial begin
        int peak;
        void'($urandom(32'hb82a59f2));
        I_RST_N   = 1'b0;
        I_START   = 1'b0;
        I_CLEAR   = 1'b0;
        I_DATA    = '{default: '0};
        model_max = -(1 << (D_W - 1));
        model_sum = 0;
        test_name = "reset";
        repeat (8) @(negedge I_CLK);
        I_RST_N = 1'b1;
        @(negedge I_CLK);

        clear_stats();
        fill_random(-128, 127);
        run_chunk("single");

        // maxima rise by 1, 2, 4, 8 and 16 so the rescale shrinks to zero
        clear_stats();
        for (int k = 0; k < 6; k++) begin
            peak = -41 + (1 << k);
            fill_random(peak - 10, peak);
            I_DATA[k] = D_W'(peak);
            run_chunk($sformatf("chain%0d", k));
        end

        test_name = "abort";
        fill_random(-128, 127);
        I_START = 1'b1;
        repeat (12) @(negedge I_CLK); // dividers busy by now
        I_START = 1'b0;
        repeat (softmax_pkg::DIV_STEPS + 8) @(negedge I_CLK);
        check("abort x_max", model_max, int'(O_X_MAX));
        check("abort exp_sum", model_sum, int'(O_EXP_SUM));
        clear_stats();
        check("clear x_max", -(1 << (D_W - 1)), int'(O_X_MAX));
        check("clear exp_sum", 0, int'(O_EXP_SUM));

        I_DATA = '{default: 8'sd37};
        run_chunk("equal");
        check("equal exp_sum", NUM << softmax_pkg::SUM_FRAC, int'(O_EXP_SUM));
        run_chunk("equal again");

        clear_stats();
        I_DATA    = '{default: 8'sh80};
        I_DATA[5] = 8'sd127;
        run_chunk("spread");
        check("spread winner", 255, int'(O_DATA[5]));
        @(negedge I_CLK);

        if (i_dut.u_softmax.u_props.fails != 0) begin
            stop_run("assertions in safe_softmax failed");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

// File: tb_softmax_properties.sv
`timescale 1ns/100ps
module softmax_properties (
    input logic                        I_CLK,
    input logic                        I_RST_N,
    input logic                        I_VLD,
    input logic                        I_DIV_START,
    input softmax_pkg::softmax_state_e I_STATE
);

    int fails = 0; // failed assertion count

    vld_pulse: assert property (@(posedge I_CLK) disable iff (!I_RST_N) I_VLD |=> !I_VLD)
        else begin
            fails++;
            $error("valid pulse lasted more than one cycle");
        end

    state_onehot: assert property (@(posedge I_CLK) disable iff (!I_RST_N) $onehot(I_STATE))
        else begin
            fails++;
            $error("FSM state is not one-hot");
        end

    idle_no_div: assert property (@(posedge I_CLK) disable iff (!I_RST_N)
        (I_STATE == softmax_pkg::IDLE) |-> !I_DIV_START)
        else begin
            fails++;
            $error("divider start high in IDLE");
        end

endmodule

bind safe_softmax softmax_properties u_props (
    .I_CLK       (I_CLK),
    .I_RST_N     (I_RST_N),
    .I_VLD       (O_VLD),
    .I_DIV_START (div_start),
    .I_STATE     (state)
);

// File: softmax_top.sv
`timescale 1ns/100ps
module softmax_top #(
    parameter int D_W = 8,
    parameter int NUM = 16
) (
    input  logic                          I_CLK,
    input  logic                          I_RST_N,
    input  logic                          I_START,
    input  logic                          I_CLEAR,
    input  logic signed [D_W-1:0]         I_DATA [0:NUM-1],
    output logic [7:0]                    O_DATA [0:NUM-1],
    output logic                          O_VLD,
    output logic signed [D_W-1:0]         O_X_MAX,
    output logic [softmax_pkg::SUM_W-1:0] O_EXP_SUM
);

    logic signed [D_W-1:0]         chunk_x_max;
    logic [softmax_pkg::SUM_W-1:0] chunk_exp_sum;

    safe_softmax #(
        .D_W (D_W),
        .NUM (NUM)
    ) u_softmax (
        .I_CLK     (I_CLK),
        .I_RST_N   (I_RST_N),
        .I_START   (I_START),
        .I_DATA    (I_DATA),
        .I_X_MAX   (O_X_MAX),         // carried statistics
        .I_EXP_SUM (O_EXP_SUM),
        .O_X_MAX   (chunk_x_max),
        .O_EXP_SUM (chunk_exp_sum),
        .O_VLD     (O_VLD),
        .O_DATA    (O_DATA)
    );

    softmax_running_stats #(
        .D_W (D_W)
    ) u_stats (
        .I_CLK     (I_CLK),
        .I_RST_N   (I_RST_N),
        .I_CLEAR   (I_CLEAR),
        .I_VLD     (O_VLD),
        .I_X_MAX   (chunk_x_max),
        .I_EXP_SUM (chunk_exp_sum),
        .O_X_MAX   (O_X_MAX),
        .O_EXP_SUM (O_EXP_SUM)
    );

endmodule

// File: safe_softmax.sv
`timescale 1ns/100ps
module safe_softmax #(
    parameter int D_W = 8,
    parameter int NUM = 16
) (
    input  logic                          I_CLK,
    input  logic                          I_RST_N,
    input  logic                          I_START,    // level, held while calculating
    input  logic signed [D_W-1:0]         I_DATA [0:NUM-1],
    input  logic signed [D_W-1:0]         I_X_MAX,    // carried from earlier chunks
    input  logic [softmax_pkg::SUM_W-1:0] I_EXP_SUM,
    output logic signed [D_W-1:0]         O_X_MAX,
    output logic [softmax_pkg::SUM_W-1:0] O_EXP_SUM,
    output logic                          O_VLD,
    output logic [7:0]                    O_DATA [0:NUM-1]
);

    localparam int EXP_W = softmax_pkg::EXP_W;
    localparam int SUM_W = softmax_pkg::SUM_W;
    localparam int CUT   = softmax_pkg::EXP_FRAC - softmax_pkg::SUM_FRAC; // Q1.15 to Q.5
    localparam int ACC_W = SUM_W + $clog2(NUM + 1) + 1;

    softmax_pkg::softmax_state_e state;

    logic                   sum_phase;
    logic                   div_start;
    logic signed [D_W-1:0]  chunk_max;
    logic signed [D_W-1:0]  x_max;
    logic signed [D_W:0]    diff [0:NUM-1];
    logic signed [D_W:0]    old_diff;
    logic [EXP_W-1:0]       lane_exp [0:NUM-1];
    logic [EXP_W-1:0]       lane_exp_r [0:NUM-1];
    logic [EXP_W-1:0]       rescale;
    logic [SUM_W+EXP_W-1:0] old_scaled;
    logic [ACC_W-1:0]       acc;
    logic [SUM_W-1:0]       new_sum;
    logic [7:0]             quot [0:NUM-1];
    logic [NUM-1:0]         div_done;
    logic                   done_all;

    // logit difference to Q8.8
    function automatic logic signed [15:0] to_q88(input logic signed [D_W:0] d);
        if (d < -128) begin
            return 16'sh8000;   // exponent is zero well before this
        end
        return {8'(d), 8'h00};
    endfunction

    softmax_max_select #(
        .D_W (D_W),
        .NUM (NUM)
    ) u_max (
        .I_DATA (I_DATA),
        .O_MAX  (chunk_max)
    );

    assign x_max = (chunk_max > I_X_MAX) ? chunk_max : I_X_MAX;

    for (genvar i = 0; i < NUM; i++) begin : g_lane
        assign diff[i] = I_DATA[i] - x_max;

        softmax_exp u_exp (
            .I_X   (to_q88(diff[i])),
            .O_EXP (lane_exp[i])
        );

        softmax_divider u_div (
            .I_CLK      (I_CLK),
            .I_RST_N    (I_RST_N),
            .I_START    (div_start),
            .I_DIVIDEND (lane_exp_r[i]),
            .I_DIVISOR  (O_EXP_SUM),
            .O_QUOTIENT (quot[i]),
            .O_DONE     (div_done[i])
        );
    end

    // e^(m_old - m_new) for the carried sum
    assign old_diff = I_X_MAX - O_X_MAX;

    softmax_exp u_rescale (
        .I_X   (to_q88(old_diff)),
        .O_EXP (rescale)
    );

    assign old_scaled = I_EXP_SUM * rescale;

    always_comb begin
        acc = ACC_W'(old_scaled[softmax_pkg::EXP_FRAC +: SUM_W]);
        for (int i = 0; i < NUM; i++) begin
            acc = acc + ACC_W'(lane_exp_r[i] >> CUT);
        end
    end

    assign new_sum  = (acc[ACC_W-1:SUM_W] != '0) ? '1 : acc[SUM_W-1:0];
    assign done_all = &div_done;

    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            state     <= softmax_pkg::IDLE;
            sum_phase <= 1'b0;
            div_start <= 1'b0;
            O_VLD     <= 1'b0;
        end else begin
            O_VLD <= 1'b0;
            case (state)
                softmax_pkg::IDLE: begin
                    sum_phase <= 1'b0;
                    if (I_START) begin
                        state <= softmax_pkg::SUM;
                    end
                end
                softmax_pkg::SUM: begin
                    if (!I_START) begin
                        state     <= softmax_pkg::IDLE;
                        sum_phase <= 1'b0;
                    end else if (!sum_phase) begin
                        sum_phase <= 1'b1;         // exponents registered
                    end else begin
                        state     <= softmax_pkg::DIVIDE;
                        sum_phase <= 1'b0;
                        div_start <= 1'b1;         // sum latched, dividers go
                    end
                end
                softmax_pkg::DIVIDE: begin
                    if (!I_START) begin
                        state     <= softmax_pkg::IDLE;
                        div_start <= 1'b0;
                    end else if (done_all) begin
                        state     <= softmax_pkg::DONE;
                        div_start <= 1'b0;
                    end
                end
                softmax_pkg::DONE: begin
                    state <= softmax_pkg::IDLE;
                    O_VLD <= 1'b1;
                end
                default: begin
                    state <= softmax_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge I_CLK) begin
        if (state == softmax_pkg::SUM && I_START && !sum_phase) begin
            lane_exp_r <= lane_exp;
            O_X_MAX    <= x_max;
        end
        if (state == softmax_pkg::SUM && I_START && sum_phase) begin
            O_EXP_SUM <= new_sum;
        end
        if (state == softmax_pkg::DIVIDE && I_START && done_all) begin
            O_DATA <= quot;
        end
    end

endmodule

// File: softmax_running_stats.sv
`timescale 1ns/100ps
module softmax_running_stats #(
    parameter int D_W = 8
) (
    input  logic                          I_CLK,
    input  logic                          I_RST_N,
    input  logic                          I_CLEAR,
    input  logic                          I_VLD,
    input  logic signed [D_W-1:0]         I_X_MAX,
    input  logic [softmax_pkg::SUM_W-1:0] I_EXP_SUM,
    output logic signed [D_W-1:0]         O_X_MAX,
    output logic [softmax_pkg::SUM_W-1:0] O_EXP_SUM
);

    localparam logic signed [D_W-1:0] MOST_NEG = {1'b1, {(D_W-1){1'b0}}};

    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            O_X_MAX   <= MOST_NEG;
            O_EXP_SUM <= '0;
        end else if (I_CLEAR) begin
            O_X_MAX   <= MOST_NEG;       // start of a new vector
            O_EXP_SUM <= '0;
        end else if (I_VLD) begin
            O_X_MAX   <= I_X_MAX;
            O_EXP_SUM <= I_EXP_SUM;
        end
    end

endmodule

// File: softmax_divider.sv
`timescale 1ns/100ps
module softmax_divider (
    input  logic                          I_CLK,
    input  logic                          I_RST_N,
    input  logic                          I_START,     // held for the whole division
    input  logic [softmax_pkg::EXP_W-1:0] I_DIVIDEND,  // Q1.15
    input  logic [softmax_pkg::SUM_W-1:0] I_DIVISOR,   // Q11.5
    output logic [7:0]                    O_QUOTIENT,  // Q0.8
    output logic                          O_DONE
);

    localparam int SUM_W = softmax_pkg::SUM_W;
    localparam int N_W   = softmax_pkg::DIV_STEPS;
    localparam int ALIGN = 16 - softmax_pkg::EXP_FRAC + softmax_pkg::SUM_FRAC; // 16 frac bits out
    localparam int CNT_W = $clog2(N_W);

    logic             busy;
    logic [CNT_W-1:0] cnt;
    logic [N_W-1:0]   num;   // dividend bits out, quotient bits in
    logic [SUM_W-1:0] rem;
    logic [SUM_W-1:0] den;
    logic [SUM_W:0]   part;
    logic [N_W-8:0]   rnd;

    assign part = {rem, num[N_W-1]};

    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            busy   <= 1'b0;
            O_DONE <= 1'b0;
            cnt    <= '0;
        end else if (!I_START) begin
            busy   <= 1'b0;
            O_DONE <= 1'b0;
            cnt    <= '0;
        end else if (!busy && !O_DONE) begin
            busy <= 1'b1;                  // load cycle
            cnt  <= '0;
        end else if (busy) begin
            cnt <= cnt + 1'b1;
            if (cnt == CNT_W'(N_W - 1)) begin
                busy   <= 1'b0;
                O_DONE <= 1'b1;            // held until start drops
            end
        end
    end

    always_ff @(posedge I_CLK) begin
        if (I_START && !busy && !O_DONE) begin
            num <= N_W'({I_DIVIDEND, {ALIGN{1'b0}}});
            rem <= '0;
            den <= I_DIVISOR;
        end else if (I_START && busy) begin
            if (part >= {1'b0, den}) begin
                rem <= SUM_W'(part - {1'b0, den});
                num <= {num[N_W-2:0], 1'b1};
            end else begin
                rem <= part[SUM_W-1:0];
                num <= {num[N_W-2:0], 1'b0};
            end
        end
    end

    // round on bit 7, saturate at 255
    assign rnd = {1'b0, num[N_W-1:8]} + (N_W-7)'(num[7]);

    assign O_QUOTIENT = (den == '0)              ? 8'h00 :
                        (rnd[N_W-8:8] != '0)     ? 8'hff : rnd[7:0];

endmodule

// File: softmax_exp.sv
`timescale 1ns/100ps
module softmax_exp (
    input  logic signed [15:0]            I_X,   // Q8.8, x <= 0
    output logic [softmax_pkg::EXP_W-1:0] O_EXP  // Q1.15
);

    localparam int EXP_W = softmax_pkg::EXP_W;

    logic signed [25:0] prod;
    logic signed [17:0] t;      // x*log2(e), Q10.8
    logic signed [9:0]  t_int;
    logic [9:0]         shift;
    logic [7:0]         frac;
    logic [EXP_W-1:0]   mant;

    // e^x = 2^t, t split into floor and fraction
    assign prod  = I_X * $signed(26'(softmax_pkg::LOG2E_Q8));
    assign t     = prod[25:8];
    assign t_int = t[17:8];     // floor, never positive
    assign frac  = t[7:0];
    assign shift = 10'(-t_int);

    // 2^f approximated by 1 + f
    assign mant  = EXP_W'({1'b1, frac}) << (softmax_pkg::EXP_FRAC - 8);

    assign O_EXP = (shift > 10'd15) ? '0 : mant >> shift[3:0]; // flush tiny values

endmodule

// File: softmax_max_select.sv
`timescale 1ns/100ps
module softmax_max_select #(
    parameter int D_W = 8,
    parameter int NUM = 16
) (
    input  logic signed [D_W-1:0] I_DATA [0:NUM-1],
    output logic signed [D_W-1:0] O_MAX
);

    localparam int LVL  = $clog2(NUM);
    localparam int LEAF = 1 << LVL;

    logic signed [D_W-1:0] node [0:2*LEAF-2]; // heap order, root at 0

    for (genvar i = 0; i < LEAF; i++) begin : g_leaf
        if (i < NUM) begin : g_word
            assign node[LEAF-1+i] = I_DATA[i];
        end else begin : g_pad
            assign node[LEAF-1+i] = {1'b1, {(D_W-1){1'b0}}}; // most negative pad
        end
    end

    for (genvar i = 0; i < LEAF-1; i++) begin : g_cmp
        assign node[i] = (node[2*i+1] > node[2*i+2]) ? node[2*i+1] : node[2*i+2];
    end

    assign O_MAX = node[0];

endmodule

// File: softmax_pkg.sv
package softmax_pkg;

    // exponent format, unsigned Q1.15 with 1.0 as the largest value
    localparam int EXP_W     = 16;
    localparam int EXP_FRAC  = 15;

    // exponent sum, unsigned Q11.5
    localparam int SUM_W     = 16;
    localparam int SUM_FRAC  = 5;

    localparam int LOG2E_Q8  = 369; // log2(e) in Q8.8
    localparam int DIV_STEPS = 24;  // restoring divider iterations

    typedef enum logic [3:0] {
        IDLE   = 4'b0001,
        SUM    = 4'b0010,
        DIVIDE = 4'b0100,
        DONE   = 4'b1000
    } softmax_state_e;

endpackage
